//--- fv_mem.f
+incdir+hdl
hdl/fv_mem_pkg.sv
hdl/fv_bank_if.sv
hdl/fv_req_fifo.sv
hdl/fv_port_arbiter.sv
hdl/fv_mem_cntl.sv
hdl/fv_bank.sv
hdl/fv_mem_top.sv
testbench/fv_mem_tb.sv

//--- hdl/fv_bank.sv
// one single-port memory bank with a busy timer and a tagged response one cycle after access
`timescale 1ns/100ps
`default_nettype none
`include "fv_mem_params.svh"

module fv_bank (
    input logic clk,
    input logic reset,
    fv_bank_if.bank port
);

    localparam int WORDS = 2 ** `FV_BANK_DEPTH_W;
    localparam int CNT_W = $clog2(`FV_BANK_BUSY + 1);

    logic [`FV_DATA_W-1:0] mem [0:WORDS-1];
    logic [`FV_BANK_DEPTH_W-1:0] word;
    logic [CNT_W-1:0] busy_cnt;

    assign word = port.req.addr[`FV_BANK_DEPTH_W-1:0];

    // busy already in the access cycle, then the counter covers the rest
    assign port.busy = port.req_valid || (busy_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
            port.rsp_valid <= 1'b0;
        end else begin
            port.rsp_valid <= port.req_valid;
            if (port.req_valid)
                busy_cnt <= CNT_W'(`FV_BANK_BUSY - 1);
            else if (busy_cnt != '0)
                busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // reads return the old word, a write response carries it too
    always_ff @(posedge clk) begin
        if (port.req_valid) begin
            if (port.req.write)
                mem[word] <= port.req.wdata;
            port.rsp.rdata <= mem[word];
            port.rsp.write <= port.req.write;
            port.rsp.pe_tag <= port.req.pe_tag;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fv_bank_if.sv
// request and response signals of one bank, shared by the controller, the bank and the arbiter
`timescale 1ns/100ps
`default_nettype none

interface fv_bank_if;

    logic req_valid;
    fv_mem_pkg::fv_req_t req;
    logic busy;
    logic rsp_valid;
    fv_mem_pkg::fv_rsp_t rsp;

    modport cntl (
        output req_valid,
        output req,
        input busy
    );

    modport bank (
        input req_valid,
        input req,
        output busy,
        output rsp_valid,
        output rsp
    );

    // response side only, seen by the port arbiter
    modport rsp_sink (
        input rsp_valid,
        input rsp
    );

endinterface

`default_nettype wire

//--- hdl/fv_mem_cntl.sv
// memory controller: pops a request, waits for its bank to go idle and dispatches it
`timescale 1ns/100ps
`default_nettype none
`include "fv_mem_params.svh"

module fv_mem_cntl (
    input logic clk,
    input logic reset,
    output logic pop,
    input logic empty,
    input logic pop_valid,
    input fv_mem_pkg::fv_req_t pop_data,
    fv_bank_if.cntl banks [0:`FV_NUM_BANKS-1]
);

    localparam int NB = `FV_NUM_BANKS;

    fv_mem_pkg::fv_cntl_state_t state;
    fv_mem_pkg::fv_cntl_state_t next_state;
    fv_mem_pkg::fv_req_t req_r;
    logic next_pop;
    logic [NB-1:0] bank_busy;
    logic [`FV_BANK_SEL_W-1:0] req_bank;

    assign req_bank = fv_mem_pkg::bank_sel(req_r.addr);

    // one request to the selected bank while in complete
    for (genvar b = 0; b < NB; b++) begin : g_bank
        assign banks[b].req_valid = (state == fv_mem_pkg::COMPLETE) && (req_bank == b);
        assign banks[b].req = req_r;
        assign bank_busy[b] = banks[b].busy;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fv_mem_pkg::IDLE;
            pop <= 1'b0;
        end else begin
            state <= next_state;
            pop <= next_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (state == fv_mem_pkg::ROUTE && pop_valid)
            req_r <= pop_data;
    end

    always_comb begin
        next_state = state;
        next_pop = 1'b0;
        case (state)
            fv_mem_pkg::IDLE: begin
                if (!empty) begin
                    next_pop = 1'b1;
                    next_state = fv_mem_pkg::ROUTE;
                end
            end
            // the fifo word shows up a cycle after pop
            fv_mem_pkg::ROUTE: begin
                if (pop_valid) begin
                    if (bank_busy[fv_mem_pkg::bank_sel(pop_data.addr)])
                        next_state = fv_mem_pkg::STALL;
                    else
                        next_state = fv_mem_pkg::COMPLETE;
                end
            end
            fv_mem_pkg::STALL: begin
                if (!bank_busy[req_bank])
                    next_state = fv_mem_pkg::COMPLETE;
            end
            fv_mem_pkg::COMPLETE: begin
                if (!empty) begin
                    next_pop = 1'b1;
                    next_state = fv_mem_pkg::ROUTE;
                end else begin
                    next_state = fv_mem_pkg::IDLE;
                end
            end
            default: next_state = fv_mem_pkg::IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/fv_mem_params.svh
// size and timing macros for the feature-vector memory, included by the package and RTL
`ifndef FV_MEM_PARAMS_SVH
`define FV_MEM_PARAMS_SVH

// bank select is the top of the word address
`define FV_NUM_BANKS 4
`define FV_BANK_SEL_W 2
`define FV_BANK_DEPTH_W 8

`define FV_DATA_W 32
`define FV_FIFO_DEPTH 4

// cycles a bank stays busy, counted from the access itself
`define FV_BANK_BUSY 3

`endif

//--- hdl/fv_mem_pkg.sv
// request, response and controller-state types shared by the memory RTL and its testbench
`default_nettype none
`include "fv_mem_params.svh"

package fv_mem_pkg;

    // word address and AXI byte address widths
    localparam int ADDR_W = `FV_BANK_SEL_W + `FV_BANK_DEPTH_W;
    localparam int AXI_ADDR_W = ADDR_W + 2;

    typedef struct packed {
        logic write;
        logic [ADDR_W-1:0] addr;
        logic [`FV_DATA_W-1:0] wdata;
        logic pe_tag;
    } fv_req_t;

    typedef struct packed {
        logic write;
        logic [`FV_DATA_W-1:0] rdata;
        logic pe_tag;
    } fv_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ROUTE,
        STALL,
        COMPLETE
    } fv_cntl_state_t;

    function automatic logic [`FV_BANK_SEL_W-1:0] bank_sel(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: `FV_BANK_SEL_W];
    endfunction

endpackage

`default_nettype wire

//--- hdl/fv_mem_top.sv
// feature-vector memory top level with two AXI4-Lite slave ports and four banks
`timescale 1ns/100ps
`default_nettype none
`include "fv_mem_params.svh"

module fv_mem_top (
    input logic clk,
    input logic reset,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p0_awaddr,
    input logic p0_awvalid,
    output logic p0_awready,
    input logic [`FV_DATA_W-1:0] p0_wdata,
    input logic [`FV_DATA_W/8-1:0] p0_wstrb,
    input logic p0_wvalid,
    output logic p0_wready,
    output logic [1:0] p0_bresp,
    output logic p0_bvalid,
    input logic p0_bready,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p0_araddr,
    input logic p0_arvalid,
    output logic p0_arready,
    output logic [`FV_DATA_W-1:0] p0_rdata,
    output logic [1:0] p0_rresp,
    output logic p0_rvalid,
    input logic p0_rready,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p1_awaddr,
    input logic p1_awvalid,
    output logic p1_awready,
    input logic [`FV_DATA_W-1:0] p1_wdata,
    input logic [`FV_DATA_W/8-1:0] p1_wstrb,
    input logic p1_wvalid,
    output logic p1_wready,
    output logic [1:0] p1_bresp,
    output logic p1_bvalid,
    input logic p1_bready,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p1_araddr,
    input logic p1_arvalid,
    output logic p1_arready,
    output logic [`FV_DATA_W-1:0] p1_rdata,
    output logic [1:0] p1_rresp,
    output logic p1_rvalid,
    input logic p1_rready
);

    logic push;
    fv_mem_pkg::fv_req_t push_data;
    logic full;
    logic pop;
    logic empty;
    logic pop_valid;
    fv_mem_pkg::fv_req_t pop_data;

    fv_bank_if banks [0:`FV_NUM_BANKS-1] ();

    // axi ports share their names with the top level
    fv_port_arbiter u_arbiter (.*);

    fv_req_fifo u_fifo (
        .clk(clk),
        .reset(reset),
        .push(push),
        .push_data(push_data),
        .full(full),
        .pop(pop),
        .empty(empty),
        .pop_valid(pop_valid),
        .pop_data(pop_data)
    );

    fv_mem_cntl u_cntl (
        .clk(clk),
        .reset(reset),
        .pop(pop),
        .empty(empty),
        .pop_valid(pop_valid),
        .pop_data(pop_data),
        .banks(banks)
    );

    for (genvar g = 0; g < `FV_NUM_BANKS; g++) begin : g_bank
        fv_bank u_bank (
            .clk(clk),
            .reset(reset),
            .port(banks[g])
        );
    end

endmodule

`default_nettype wire

//--- hdl/fv_port_arbiter.sv
// two AXI4-Lite slave ports sharing the request FIFO, with bank responses routed back by tag
`timescale 1ns/100ps
`default_nettype none
`include "fv_mem_params.svh"

module fv_port_arbiter (
    input logic clk,
    input logic reset,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p0_awaddr,
    input logic p0_awvalid,
    output logic p0_awready,
    input logic [`FV_DATA_W-1:0] p0_wdata,
    input logic [`FV_DATA_W/8-1:0] p0_wstrb,
    input logic p0_wvalid,
    output logic p0_wready,
    output logic [1:0] p0_bresp,
    output logic p0_bvalid,
    input logic p0_bready,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p0_araddr,
    input logic p0_arvalid,
    output logic p0_arready,
    output logic [`FV_DATA_W-1:0] p0_rdata,
    output logic [1:0] p0_rresp,
    output logic p0_rvalid,
    input logic p0_rready,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p1_awaddr,
    input logic p1_awvalid,
    output logic p1_awready,
    input logic [`FV_DATA_W-1:0] p1_wdata,
    input logic [`FV_DATA_W/8-1:0] p1_wstrb,
    input logic p1_wvalid,
    output logic p1_wready,
    output logic [1:0] p1_bresp,
    output logic p1_bvalid,
    input logic p1_bready,
    input logic [fv_mem_pkg::AXI_ADDR_W-1:0] p1_araddr,
    input logic p1_arvalid,
    output logic p1_arready,
    output logic [`FV_DATA_W-1:0] p1_rdata,
    output logic [1:0] p1_rresp,
    output logic p1_rvalid,
    input logic p1_rready,
    output logic push,
    output fv_mem_pkg::fv_req_t push_data,
    input logic full,
    fv_bank_if.rsp_sink banks [0:`FV_NUM_BANKS-1]
);

    localparam int NB = `FV_NUM_BANKS;
    localparam int AW = fv_mem_pkg::AXI_ADDR_W;
    localparam int DW = `FV_DATA_W;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic [1:0] awvalid;
    logic [1:0] wvalid;
    logic [1:0] arvalid;
    logic [1:0] bready;
    logic [1:0] rready;
    logic [AW-1:0] awaddr [0:1];
    logic [AW-1:0] araddr [0:1];
    logic [DW-1:0] wdata [0:1];
    logic [DW-1:0] rdata [0:1];
    logic [1:0] outstanding;
    logic [1:0] want_wr;
    logic [1:0] want_rd;
    logic [1:0] grant;
    logic [1:0] bvalid;
    logic [1:0] rvalid;
    logic rr_ptr;
    logic sel;
    logic [NB-1:0] bank_rsp_valid;
    fv_mem_pkg::fv_rsp_t bank_rsp [0:NB-1];
    logic in_valid;
    fv_mem_pkg::fv_rsp_t in_rsp;

    // both ports folded into arrays, index is the pe tag
    assign awvalid = {p1_awvalid, p0_awvalid};
    assign wvalid = {p1_wvalid, p0_wvalid};
    assign arvalid = {p1_arvalid, p0_arvalid};
    assign bready = {p1_bready, p0_bready};
    assign rready = {p1_rready, p0_rready};
    assign awaddr[0] = p0_awaddr;
    assign awaddr[1] = p1_awaddr;
    assign araddr[0] = p0_araddr;
    assign araddr[1] = p1_araddr;
    assign wdata[0] = p0_wdata;
    assign wdata[1] = p1_wdata;

    // wstrb is not honoured, every write stores the whole word
    assign want_wr = awvalid & wvalid & ~outstanding;
    assign want_rd = arvalid & ~outstanding;

    always_comb begin
        grant = 2'b00;
        if (!full) begin
            if ((want_wr | want_rd) == 2'b11)
                grant[rr_ptr] = 1'b1;
            else
                grant = want_wr | want_rd;
        end
    end

    // a write wins over a read on the same port
    assign p0_awready = grant[0] & want_wr[0];
    assign p0_wready = grant[0] & want_wr[0];
    assign p0_arready = grant[0] & ~want_wr[0];
    assign p1_awready = grant[1] & want_wr[1];
    assign p1_wready = grant[1] & want_wr[1];
    assign p1_arready = grant[1] & ~want_wr[1];

    assign sel = grant[1];
    assign push = |grant;
    assign push_data.write = want_wr[sel];
    assign push_data.addr = want_wr[sel] ? awaddr[sel][AW-1:2] : araddr[sel][AW-1:2];
    assign push_data.wdata = wdata[sel];
    assign push_data.pe_tag = sel;

    for (genvar b = 0; b < NB; b++) begin : g_rsp
        assign bank_rsp_valid[b] = banks[b].rsp_valid;
        assign bank_rsp[b] = banks[b].rsp;
    end

    // at most one bank answers per cycle
    always_comb begin
        in_valid = |bank_rsp_valid;
        in_rsp = bank_rsp[0];
        for (int b = 0; b < NB; b++) begin
            if (bank_rsp_valid[b])
                in_rsp = bank_rsp[b];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= 1'b0;
            outstanding <= 2'b00;
            bvalid <= 2'b00;
            rvalid <= 2'b00;
        end else begin
            if (push)
                rr_ptr <= ~grant[1];
            for (int p = 0; p < 2; p++) begin
                if (grant[p])
                    outstanding[p] <= 1'b1;
                else if ((bvalid[p] && bready[p]) || (rvalid[p] && rready[p]))
                    outstanding[p] <= 1'b0;
                if (in_valid && in_rsp.pe_tag == 1'(p)) begin
                    bvalid[p] <= in_rsp.write;
                    rvalid[p] <= !in_rsp.write;
                end else begin
                    if (bready[p])
                        bvalid[p] <= 1'b0;
                    if (rready[p])
                        rvalid[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (in_valid && !in_rsp.write && in_rsp.pe_tag == 1'(p))
                rdata[p] <= in_rsp.rdata;
        end
    end

    assign p0_bvalid = bvalid[0];
    assign p0_bresp = RESP_OKAY;
    assign p0_rvalid = rvalid[0];
    assign p0_rdata = rdata[0];
    assign p0_rresp = RESP_OKAY;
    assign p1_bvalid = bvalid[1];
    assign p1_bresp = RESP_OKAY;
    assign p1_rvalid = rvalid[1];
    assign p1_rdata = rdata[1];
    assign p1_rresp = RESP_OKAY;

endmodule

`default_nettype wire

//--- hdl/fv_req_fifo.sv
// request FIFO between the port arbiter and the memory controller, data valid a cycle after pop
`timescale 1ns/100ps
`default_nettype none
`include "fv_mem_params.svh"

module fv_req_fifo (
    input logic clk,
    input logic reset,
    input logic push,
    input fv_mem_pkg::fv_req_t push_data,
    output logic full,
    input logic pop,
    output logic empty,
    output logic pop_valid,
    output fv_mem_pkg::fv_req_t pop_data
);

    localparam int DEPTH = `FV_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    fv_mem_pkg::fv_req_t mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic do_push;
    logic do_pop;

    assign full = (count == DEPTH);
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= do_pop;
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
        if (do_pop)
            pop_data <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f fv_mem.f --top-module fv_mem_tb \
    -o fv_mem_sim || exit 1
out=$(./obj_dir/fv_mem_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1

//--- testbench/fv_mem_tb.sv
// testbench for the feature-vector memory, drives both AXI4-Lite ports against a read model
`timescale 1ns/100ps
`default_nettype none
`include "fv_mem_params.svh"

module fv_mem_tb;

    localparam int TIMEOUT = 200;
    localparam int AW = fv_mem_pkg::ADDR_W;
    localparam int DW = `FV_DATA_W;
    localparam int W_ACC = 0;
    localparam int R_ACC = 1;
    localparam int B_RSP = 2;
    localparam int R_RSP = 3;

    logic clk;
    logic reset;
    logic [AW+1:0] awaddr [0:1];
    logic [AW+1:0] araddr [0:1];
    logic [DW-1:0] wdata [0:1];
    logic [DW/8-1:0] wstrb [0:1];
    logic [1:0] awvalid;
    logic [1:0] wvalid;
    logic [1:0] arvalid;
    logic [1:0] bready;
    logic [1:0] rready;
    logic [1:0] awready;
    logic [1:0] wready;
    logic [1:0] arready;
    logic [1:0] bvalid;
    logic [1:0] rvalid;
    logic [1:0] bresp [0:1];
    logic [1:0] rresp [0:1];
    logic [DW-1:0] rdata [0:1];

    // reference model and per-port transaction records
    logic [DW-1:0] model [0:2**AW-1];
    logic written [0:2**AW-1];
    logic [AW-1:0] rd_addr [0:1];
    logic [AW-1:0] wr_addr [0:1];
    logic [DW-1:0] wr_data [0:1];
    int errors;
    int checks;

    fv_mem_top DUT (
        .clk(clk), .reset(reset),
        .p0_awaddr(awaddr[0]), .p0_awvalid(awvalid[0]), .p0_awready(awready[0]),
        .p0_wdata(wdata[0]), .p0_wstrb(wstrb[0]), .p0_wvalid(wvalid[0]), .p0_wready(wready[0]),
        .p0_bresp(bresp[0]), .p0_bvalid(bvalid[0]), .p0_bready(bready[0]),
        .p0_araddr(araddr[0]), .p0_arvalid(arvalid[0]), .p0_arready(arready[0]),
        .p0_rdata(rdata[0]), .p0_rresp(rresp[0]), .p0_rvalid(rvalid[0]), .p0_rready(rready[0]),
        .p1_awaddr(awaddr[1]), .p1_awvalid(awvalid[1]), .p1_awready(awready[1]),
        .p1_wdata(wdata[1]), .p1_wstrb(wstrb[1]), .p1_wvalid(wvalid[1]), .p1_wready(wready[1]),
        .p1_bresp(bresp[1]), .p1_bvalid(bvalid[1]), .p1_bready(bready[1]),
        .p1_araddr(araddr[1]), .p1_arvalid(arvalid[1]), .p1_arready(arready[1]),
        .p1_rdata(rdata[1]), .p1_rresp(rresp[1]), .p1_rvalid(rvalid[1]), .p1_rready(rready[1])
    );

    always #50 clk = ~clk;

    function automatic logic [DW-1:0] ref_read(input logic [AW-1:0] addr);
        return model[addr];
    endfunction

    // bit 0 of the word address picks the owning port, so ports never share a word
    function automatic logic [AW-1:0] port_addr(input logic p, input logic [1:0] bank,
                                                input logic [6:0] word);
        return {bank, word, p};
    endfunction

    function automatic logic seen_high(input int kind, input logic p);
        case (kind)
            W_ACC: return awready[p] && wready[p];
            R_ACC: return arready[p];
            B_RSP: return bvalid[p];
            default: return rvalid[p];
        endcase
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic wait_for(input int kind, input logic p, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!seen_high(kind, p) && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (!seen_high(kind, p))
            stop_on_timeout(what);
    endtask

    // keeps the response waiting, then completes the handshake
    task automatic hold_response(input logic p, input logic is_read, input int max_delay);
        int hold;
        logic [DW-1:0] first;
        hold = $urandom_range(max_delay, 0);
        first = rdata[p];
        checks++;
        assert ((is_read ? rresp[p] : bresp[p]) == 2'b00) else begin
            $display("Mismatch %s port %0d expected 0 actual %h", is_read ? "rresp" : "bresp",
                     p, is_read ? rresp[p] : bresp[p]);
            errors++;
        end
        // a new transaction is offered and must not be taken while the response waits
        repeat (hold) begin
            @(posedge clk);
            awvalid[p] <= 1'b1;
            wvalid[p] <= 1'b1;
            arvalid[p] <= 1'b1;
            @(negedge clk);
            checks++;
            assert (seen_high(is_read ? R_RSP : B_RSP, p)) else begin
                $display("port %0d dropped its response before the handshake", p);
                errors++;
            end
            assert (!is_read || rdata[p] == first) else begin
                $display("Mismatch rdata held port %0d expected %h actual %h",
                         p, first, rdata[p]);
                errors++;
            end
            assert (!awready[p] && !wready[p] && !arready[p]) else begin
                $display("port %0d raised a ready while its response was pending", p);
                errors++;
            end
        end
        @(posedge clk);
        awvalid[p] <= 1'b0;
        wvalid[p] <= 1'b0;
        arvalid[p] <= 1'b0;
        if (is_read)
            rready[p] <= 1'b1;
        else
            bready[p] <= 1'b1;
        @(posedge clk);
        rready[p] <= 1'b0;
        bready[p] <= 1'b0;
    endtask

    task automatic axi_write(input logic p, input logic [AW-1:0] addr, input logic [DW-1:0] data,
                             input int max_delay);
        wr_addr[p] = addr;
        wr_data[p] = data;
        @(posedge clk);
        awaddr[p] <= {addr, 2'b00};
        wdata[p] <= data;
        awvalid[p] <= 1'b1;
        wvalid[p] <= 1'b1;
        wait_for(W_ACC, p, "awready and wready");
        @(posedge clk);
        awvalid[p] <= 1'b0;
        wvalid[p] <= 1'b0;
        wait_for(B_RSP, p, "bvalid");
        hold_response(p, 1'b0, max_delay);
    endtask

    task automatic axi_read(input logic p, input logic [AW-1:0] addr, input int max_delay);
        rd_addr[p] = addr;
        @(posedge clk);
        araddr[p] <= {addr, 2'b00};
        arvalid[p] <= 1'b1;
        wait_for(R_ACC, p, "arready");
        @(posedge clk);
        arvalid[p] <= 1'b0;
        wait_for(R_RSP, p, "rvalid");
        hold_response(p, 1'b1, max_delay);
    endtask

    // a negative bank means any bank; unwritten words are always written first
    task automatic random_traffic(input logic p, input int count, input int max_delay,
                                  input int bank);
        logic [AW-1:0] addr;
        logic [1:0] b;
        for (int i = 0; i < count; i++) begin
            b = (bank < 0) ? 2'($urandom_range(3, 0)) : 2'(bank);
            addr = port_addr(p, b, 7'($urandom_range(31, 0)));
            if (!written[addr] || $urandom_range(1, 0) == 0) begin
                axi_write(p, addr, $urandom, max_delay);
                written[addr] = 1'b1;
            end else begin
                axi_read(p, addr, max_delay);
            end
            repeat ($urandom_range(max_delay, 0)) @(posedge clk);
        end
    endtask

    task automatic report_test(input int num, input string name, input int start);
        $display("test %0d %s: %0d errors", num, name, errors - start);
    endtask

    // compares read data and updates the model on write responses
    always @(negedge clk) begin
        if (!reset) begin
            for (int i = 0; i < 2; i++) begin
                if (rvalid[i] && rready[i]) begin
                    checks++;
                    assert (rdata[i] == ref_read(rd_addr[i])) else begin
                        $display("Mismatch rdata port %0d addr %h expected %h actual %h",
                                 i, rd_addr[i], ref_read(rd_addr[i]), rdata[i]);
                        errors++;
                    end
                end
                if (bvalid[i] && bready[i])
                    model[wr_addr[i]] = wr_data[i];
            end
        end
    end

    initial begin
        int start;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        void'($urandom(32'h3ee1_022b));
        clk = 1'b0;
        errors = 0;
        checks = 0;
        reset <= 1'b1;
        {awvalid, wvalid, arvalid, bready, rready} <= '0;
        for (int p = 0; p < 2; p++) begin
            awaddr[p] <= '0;
            araddr[p] <= '0;
            wdata[p] <= '0;
            wstrb[p] <= '1;
        end
        for (int i = 0; i < 2**AW; i++) begin
            model[i] = 32'hc0de_0000 | 32'(i);
            written[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        start = errors;
        for (int b = 0; b < 4; b++) begin
            for (int p = 0; p < 2; p++) begin
                addr = port_addr(p[0], b[1:0], 7'($urandom));
                data = $urandom;
                axi_write(p[0], addr, data, 0);
                written[addr] = 1'b1;
                axi_read(p[0], addr, 0);
            end
        end
        report_test(1, "write and read back on every bank", start);

        start = errors;
        fork
            random_traffic(1'b0, 30, 0, 2);
            random_traffic(1'b1, 30, 0, 2);
        join
        random_traffic(1'b0, 30, 0, -1);
        report_test(2, "same bank back to back and spread banks", start);

        start = errors;
        fork
            random_traffic(1'b0, 60, 0, -1);
            random_traffic(1'b1, 60, 0, -1);
        join
        report_test(3, "both ports at once", start);

        start = errors;
        fork
            random_traffic(1'b0, 30, 8, -1);
            random_traffic(1'b1, 30, 8, -1);
        join
        report_test(4, "response back-pressure", start);

        start = errors;
        fork
            random_traffic(1'b0, 300, 4, -1);
            random_traffic(1'b1, 300, 4, -1);
        join
        report_test(5, "random mixed traffic", start);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
